// ==== compile.f ====
+incdir+hw
hw/rv_pkg.sv
hw/immediate_generator.sv
hw/instruction_decoder.sv
hw/register_file.sv
hw/alu.sv
hw/pipe_stage.sv
hw/rv_int_core.sv
verification/rv_int_core_checker.sv
verification/tb_rv_int_core.sv

// ==== Makefile ====
# Verilator build and run of the RV32I integer slice testbench
TOP := tb_rv_int_core

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --assert --top-module $(TOP) -f compile.f -o $(TOP)

# Pass only when the testbench printed its pass line
run: compile
	@out="$$(./obj_dir/$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "sim passed"

clean:
	rm -rf obj_dir

// ==== verification/tb_rv_int_core.sv ====
/*
 * Testbench for the RV32I integer slice
 * Random instruction stream against an in-order ISA model, then a register dump
 */

`timescale 1ns/100ps

`include "rv_defs.svh"

module tb_rv_int_core import rv_pkg::*; ();

  localparam int N_RANDOM     = 3000;
  localparam int N_TOTAL      = N_RANDOM + `RV_NREGS;
  localparam int RESET_CYCLES = 16;
  // Four cycles per instruction is far above the stalled throughput
  localparam int CYCLE_LIMIT  = 4 * N_TOTAL + RESET_CYCLES;

  logic                clock = 1'b0;
  logic                rst;
  logic                in_valid;
  logic                in_ready;
  logic [`RV_ILEN-1:0] in_inst;
  logic [`RV_XLEN-1:0] in_pc;
  logic                out_valid;
  logic                out_ready;
  result_t             out_result;

  // Architectural state as seen in issue order
  logic [`RV_XLEN-1:0] model_regs [`RV_NREGS];
  result_t             expected_q [$];
  result_t             expected;
  logic [`RV_XLEN-1:0] pc_next;
  int                  cycles;
  int                  issued;
  int                  retired;
  int                  extra;

  always #50 clock = ~clock;

  rv_int_core rv_int_core_inst (
    .clock      (clock),
    .rst        (rst),
    .in_valid   (in_valid),
    .in_ready   (in_ready),
    .in_inst    (in_inst),
    .in_pc      (in_pc),
    .out_valid  (out_valid),
    .out_ready  (out_ready),
    .out_result (out_result)
  );

  task automatic abort_run();
    $display("sim failed");
    $fatal(1, "run stopped at first failure");
  endtask

  task automatic check_result(input result_t got, input result_t want);
    if (got !== want) begin
      $display("[ERROR] out_result for pc %h: got %h, expected %h", want.pc, got, want);
      abort_run();
    end
  endtask

  task automatic check_reg(input logic [`RV_REG_W-1:0] idx, input logic [`RV_XLEN-1:0] got);
    if (got !== model_regs[idx]) begin
      $display("[ERROR] out_result.wb_data for x%0d: got %h, expected %h",
               idx, got, model_regs[idx]);
      abort_run();
    end
  endtask

  // Mostly x0..x7 so back-to-back dependencies are common
  function automatic logic [4:0] pick_reg();
    if (($urandom % 8) != 0) begin
      return 5'($urandom % 8);
    end
    return 5'($urandom);
  endfunction

  function automatic logic [31:0] random_inst();
    logic [31:0] bits;
    logic [4:0]  rd;
    logic [4:0]  rs1;
    logic [4:0]  rs2;
    logic [2:0]  f3;
    logic [2:0]  bf3;
    logic [6:0]  f7;
    logic [6:0]  opc;
    int          f;
    bits = $urandom;
    rd   = pick_reg();
    rs1  = pick_reg();
    rs2  = pick_reg();
    f3   = bits[14:12];
    // Only SUB and SRA use funct7 bit 30
    f7   = ((f3 == 3'b000) || (f3 == 3'b101)) ? {1'b0, bits[30], 5'b0} : 7'b0;
    f    = int'($urandom % 6);
    bf3  = 3'((f < 2) ? f : f + 2);
    case ($urandom % 20)
      0, 1, 2, 3, 4: return {f7, rs2, rs1, f3, rd, OPCODE_OP};
      5, 6, 7, 8, 9: begin
        // Shift immediates carry shamt plus the SRAI flag
        if ((f3 == 3'b001) || (f3 == 3'b101)) begin
          return {f7, bits[24:20], rs1, f3, rd, OPCODE_OP_IMM};
        end
        return {bits[31:20], rs1, f3, rd, OPCODE_OP_IMM};
      end
      10: return {bits[31:12], rd, OPCODE_LUI};
      11: return {bits[31:12], rd, OPCODE_AUIPC};
      12: return {bits[31:12], rd, OPCODE_JAL};
      13: return {bits[31:20], rs1, 3'b000, rd, OPCODE_JALR};
      14, 15, 16: return {bits[31:25], rs2, rs1, bf3, bits[11:7], OPCODE_BRANCH};
      17: return {bits[31:20], rs1, f3, rd, OPCODE_LOAD};
      18: return {bits[31:25], rs2, rs1, f3, bits[11:7], OPCODE_STORE};
      default: begin
        // Passthrough classes, FP memory, fence and system
        case ($urandom % 4)
          0:       opc = OPCODE_LOAD_FP;
          1:       opc = OPCODE_STORE_FP;
          2:       opc = 7'b0001111;
          default: opc = 7'b1110011;
        endcase
        return {bits[31:7], opc};
      end
    endcase
  endfunction

  // ADDI xr, xr, 0 reads a register out without changing it
  function automatic logic [31:0] readout_inst(logic [4:0] r);
    return {12'h000, r, 3'b000, r, OPCODE_OP_IMM};
  endfunction

  // RV32I integer semantics, arith picks SRA, sub picks SUB
  function automatic logic [31:0] ref_alu(logic [2:0] f3, logic sub, logic arith,
                                          logic [31:0] x, logic [31:0] y);
    case (f3)
      3'b000:  return sub ? (x - y) : (x + y);
      3'b001:  return x << y[4:0];
      3'b010:  return {31'b0, $signed(x) < $signed(y)};
      3'b011:  return {31'b0, x < y};
      3'b100:  return x ^ y;
      3'b101: begin
        if (arith) begin
          return $signed(x) >>> y[4:0];
        end
        return x >> y[4:0];
      end
      3'b110:  return x | y;
      default: return x & y;
    endcase
  endfunction

  task automatic model_issue(input logic [31:0] inst, input logic [31:0] pc,
                             output result_t r);
    logic [31:0] a;
    logic [31:0] b;
    logic [31:0] imm_i;
    logic        take;
    a         = model_regs[inst[19:15]];
    b         = model_regs[inst[24:20]];
    imm_i     = {{20{inst[31]}}, inst[31:20]};
    take      = 1'b0;
    r         = '0;
    r.pc      = pc;
    r.rd      = inst[11:7];
    r.next_pc = pc + 32'd4;
    case (inst[6:0])
      OPCODE_OP: begin
        r.wb_en   = 1'b1;
        r.wb_data = ref_alu(inst[14:12], inst[30], inst[30], a, b);
      end
      OPCODE_OP_IMM: begin
        r.wb_en   = 1'b1;
        r.wb_data = ref_alu(inst[14:12], 1'b0, inst[30], a, imm_i);
      end
      OPCODE_LUI, OPCODE_AUIPC: begin
        r.wb_en   = 1'b1;
        r.wb_data = {inst[31:12], 12'h000} + ((inst[6:0] == OPCODE_AUIPC) ? pc : 32'h0);
      end
      OPCODE_JAL: begin
        r.wb_en   = 1'b1;
        r.wb_data = pc + 32'd4;
        r.taken   = 1'b1;
        r.next_pc = pc + {{11{inst[31]}}, inst[31], inst[19:12], inst[20], inst[30:21], 1'b0};
      end
      OPCODE_JALR: begin
        r.wb_en   = 1'b1;
        r.wb_data = pc + 32'd4;
        r.taken   = 1'b1;
        r.next_pc = (a + imm_i) & ~32'h1;
      end
      OPCODE_BRANCH: begin
        case (inst[14:12])
          3'b000:  take = (a == b);
          3'b001:  take = (a != b);
          3'b100:  take = ($signed(a) < $signed(b));
          3'b101:  take = ($signed(a) >= $signed(b));
          3'b110:  take = (a < b);
          3'b111:  take = (a >= b);
          default: take = 1'b0;
        endcase
        r.taken = take;
        if (take) begin
          r.next_pc = pc + {{19{inst[31]}}, inst[31], inst[7], inst[30:25], inst[11:8], 1'b0};
        end
      end
      OPCODE_LOAD: begin
        r.is_mem   = 1'b1;
        r.mem_addr = a + imm_i;
      end
      OPCODE_STORE: begin
        r.is_mem   = 1'b1;
        r.mem_addr = a + {{20{inst[31]}}, inst[31:25], inst[11:7]};
      end
      default: begin
      end
    endcase
    // x0 stays zero in the model too
    if (r.wb_en && (r.rd != 5'd0)) begin
      model_regs[r.rd] = r.wb_data;
    end
  endtask

  initial begin
    rst        = 1'b1;
    in_valid   = 1'b0;
    in_inst    = '0;
    in_pc      = '0;
    out_ready  = 1'b0;
    pc_next    = 32'h0000_1000;
    issued     = 0;
    retired    = 0;
    extra      = 0;
    model_regs = '{default: '0};
    void'($urandom(32'h2e14_4a96));
    repeat (RESET_CYCLES) @(posedge clock);
    rst    <= 1'b0;
    cycles = RESET_CYCLES;
    while (retired < N_TOTAL) begin
      @(posedge clock);
      cycles++;
      if (cycles > CYCLE_LIMIT) begin
        $display("Timeout after %0d cycles, %0d of %0d results seen", cycles, retired, N_TOTAL);
        abort_run();
      end
      // Accepted this edge, model it in issue order
      if (in_valid && in_ready) begin
        model_issue(in_inst, in_pc, expected);
        expected_q.push_back(expected);
        pc_next = expected.next_pc;
        issued++;
      end
      if (out_valid && out_ready) begin
        if (expected_q.size() == 0) begin
          $display("A result left the core with no instruction outstanding");
          abort_run();
        end
        check_result(out_result, expected_q.pop_front());
        if (retired >= N_RANDOM) begin
          check_reg(5'(retired - N_RANDOM), out_result.wb_data);
        end
        retired++;
      end
      // New item only once the current one is gone
      if (!in_valid || in_ready) begin
        if (issued < N_RANDOM) begin
          in_valid <= ($urandom % 10) != 0;
          in_inst  <= random_inst();
        end else if (issued < N_TOTAL) begin
          in_valid <= 1'b1;
          in_inst  <= readout_inst(5'(issued - N_RANDOM));
        end else begin
          in_valid <= 1'b0;
        end
        in_pc <= pc_next;
      end
      // Downstream stalls about 30% of the time
      out_ready <= ($urandom % 10) >= 3;
    end
    out_ready <= 1'b1;
    // Drain window, nothing more may come out
    repeat (4) begin
      @(posedge clock);
      if (out_valid) begin
        extra++;
      end
    end
    if (extra == 0) begin
      $display("sim passed");
      $finish;
    end else begin
      $display("Results out of step: %0d extra after the last expected one", extra);
      abort_run();
    end
  end

endmodule

// ==== verification/rv_int_core_checker.sv ====
/*
 * Handshake and x0 assertions for the RV32I integer slice
 * Bound into the core top level
 */

`timescale 1ns/100ps

`include "rv_defs.svh"

module rv_int_core_checker import rv_pkg::*; (
  input logic                 clock,
  input logic                 rst,
  input logic                 in_valid,
  input logic                 in_ready,
  input logic                 out_valid,
  input logic                 out_ready,
  input result_t              out_result,
  input logic [`RV_REG_W-1:0] dec_rs1,
  input logic [`RV_REG_W-1:0] dec_rs2,
  input issue_t               issue_in
);

  // Stalled output keeps its record
  a_out_hold: assert property (@(posedge clock) disable iff (rst)
    (out_valid && !out_ready) |=> (out_valid && $stable(out_result)))
    else $error("out_result changed or out_valid dropped while stalled");

  // Source sees back-pressure only once both slices are full
  a_in_backpressure: assert property (@(posedge clock) disable iff (rst)
    (in_valid && !in_ready) |-> (out_valid && !out_ready))
    else $error("in_ready dropped while the output side was moving");

  // x0 reads zero on both paths, forwarded or not
  a_x0_rs1: assert property (@(posedge clock) disable iff (rst)
    (dec_rs1 == '0) |-> (issue_in.rs1_val == '0))
    else $error("nonzero value seen for x0 on rs1");

  a_x0_rs2: assert property (@(posedge clock) disable iff (rst)
    (dec_rs2 == '0) |-> (issue_in.rs2_val == '0))
    else $error("nonzero value seen for x0 on rs2");

  a_reset_empty: assert property (@(posedge clock) rst |=> (!out_valid && in_ready))
    else $error("pipeline not empty after reset");

endmodule

bind rv_int_core rv_int_core_checker checker_inst (
  .clock      (clock),
  .rst        (rst),
  .in_valid   (in_valid),
  .in_ready   (in_ready),
  .out_valid  (out_valid),
  .out_ready  (out_ready),
  .out_result (out_result),
  .dec_rs1    (dec_rs1),
  .dec_rs2    (dec_rs2),
  .issue_in   (issue_in)
);

// ==== hw/rv_int_core.sv ====
/*
 * RV32I integer execute slice
 * Decode and register read, issue slice, execute with forwarding, result slice
 */

`timescale 1ns/100ps

`include "rv_defs.svh"

module rv_int_core import rv_pkg::*; (
  input  logic                clock,
  input  logic                rst,
  input  logic                in_valid,
  output logic                in_ready,
  input  logic [`RV_ILEN-1:0] in_inst,
  input  logic [`RV_XLEN-1:0] in_pc,
  output logic                out_valid,
  input  logic                out_ready,
  output result_t             out_result
);

  // Decode/read stage
  logic [`RV_REG_W-1:0] dec_rs1;
  logic [`RV_REG_W-1:0] dec_rs2;
  logic [`RV_REG_W-1:0] dec_rd;
  ctrl_t                dec_ctrl;
  logic [`RV_XLEN-1:0]  dec_imm;
  logic [`RV_XLEN-1:0]  rf_rs1_val;
  logic [`RV_XLEN-1:0]  rf_rs2_val;
  logic                 fwd_rs1;
  logic                 fwd_rs2;
  issue_t               issue_in;

  // Execute stage
  logic                 exec_valid;
  logic                 exec_ready;
  issue_t               exec_issue;
  result_t              exec_result;
  logic                 exec_produces;
  logic                 rf_we;

  instruction_decoder decoder_inst (
    .inst (in_inst),
    .rs1  (dec_rs1),
    .rs2  (dec_rs2),
    .rd   (dec_rd),
    .ctrl (dec_ctrl)
  );

  immediate_generator immgen_inst (
    .clock     (clock),
    .inst      (in_inst),
    .immediate (dec_imm)
  );

  // Write lands on the same edge the producer moves into result_q
  register_file regfile_inst (
    .clock   (clock),
    .rst     (rst),
    .rs1     (dec_rs1),
    .rs2     (dec_rs2),
    .rs1_val (rf_rs1_val),
    .rs2_val (rf_rs2_val),
    .we      (rf_we),
    .wa      (exec_result.rd),
    .wd      (exec_result.wb_data)
  );

  // Execute holds the only not-yet-written producer
  assign exec_produces = exec_valid && exec_issue.ctrl.wb_en && (exec_issue.rd != '0);
  assign fwd_rs1       = exec_produces && (exec_issue.rd == dec_rs1);
  assign fwd_rs2       = exec_produces && (exec_issue.rd == dec_rs2);

  always_comb begin
    issue_in.pc      = in_pc;
    issue_in.imm     = dec_imm;
    issue_in.rs1_val = fwd_rs1 ? exec_result.wb_data : rf_rs1_val;
    issue_in.rs2_val = fwd_rs2 ? exec_result.wb_data : rf_rs2_val;
    issue_in.rd      = dec_rd;
    issue_in.ctrl    = dec_ctrl;
  end

  pipe_stage #(.T(issue_t)) issue_q (
    .clock     (clock),
    .rst       (rst),
    .in_valid  (in_valid),
    .in_ready  (in_ready),
    .in_data   (issue_in),
    .out_valid (exec_valid),
    .out_ready (exec_ready),
    .out_data  (exec_issue)
  );

  alu alu_inst (
    .issue  (exec_issue),
    .result (exec_result)
  );

  // Retire into result_q, stalls with back-pressure
  assign rf_we = exec_valid && exec_ready && exec_result.wb_en;

  pipe_stage #(.T(result_t)) result_q (
    .clock     (clock),
    .rst       (rst),
    .in_valid  (exec_valid),
    .in_ready  (exec_ready),
    .in_data   (exec_result),
    .out_valid (out_valid),
    .out_ready (out_ready),
    .out_data  (out_result)
  );

endmodule

// ==== hw/pipe_stage.sv ====
/*
 * Valid/ready register slice
 * One entry, one cycle latency, full throughput while downstream is ready
 */

`timescale 1ns/100ps

module pipe_stage #(
  parameter type T = logic
) (
  input  logic clock,
  input  logic rst,
  input  logic in_valid,
  output logic in_ready,
  input  T     in_data,
  output logic out_valid,
  input  logic out_ready,
  output T     out_data
);

  logic valid_q;
  T     data_q;

  // Accept when empty or when the held item leaves this cycle
  assign in_ready = !valid_q || out_ready;

  always_ff @(posedge clock) begin
    if (rst) begin
      valid_q <= 1'b0;
    end else if (in_ready) begin
      valid_q <= in_valid;
    end
  end

  // Payload only loads on a real transfer, so it holds while stalled
  always_ff @(posedge clock) begin
    if (in_valid && in_ready) begin
      data_q <= in_data;
    end
  end

  assign out_valid = valid_q;
  assign out_data  = data_q;

endmodule

// ==== hw/alu.sv ====
/*
 * Execute stage datapath
 * ALU, branch compare, next pc and effective address into one result record
 */

`timescale 1ns/100ps

`include "rv_defs.svh"

module alu import rv_pkg::*; (
  input  issue_t  issue,
  output result_t result
);

  logic [`RV_XLEN-1:0] op_a;
  logic [`RV_XLEN-1:0] op_b;
  logic [`RV_XLEN-1:0] alu_out;
  logic [`RV_XLEN-1:0] pc_plus4;
  logic [`RV_XLEN-1:0] pc_plus_imm;
  logic [4:0]          shamt;
  logic                cond;

  // Operand select, LUI gets A=0 through rs1=x0
  assign op_a  = issue.ctrl.src_a_pc ? issue.pc : issue.rs1_val;
  assign op_b  = issue.ctrl.src_b_imm ? issue.imm : issue.rs2_val;
  assign shamt = op_b[4:0];

  assign pc_plus4    = issue.pc + `RV_XLEN'(`RV_PC_STEP);
  assign pc_plus_imm = issue.pc + issue.imm;

  always_comb begin
    case (issue.ctrl.alu_op)
      ALU_ADD:  alu_out = op_a + op_b;
      ALU_SUB:  alu_out = op_a - op_b;
      ALU_SLL:  alu_out = op_a << shamt;
      ALU_SLT:  alu_out = `RV_XLEN'($signed(op_a) < $signed(op_b));
      ALU_SLTU: alu_out = `RV_XLEN'(op_a < op_b);
      ALU_XOR:  alu_out = op_a ^ op_b;
      ALU_SRL:  alu_out = op_a >> shamt;
      ALU_SRA:  alu_out = $unsigned($signed(op_a) >>> shamt);
      ALU_OR:   alu_out = op_a | op_b;
      default:  alu_out = op_a & op_b;
    endcase
  end

  // Branch condition from funct3, reserved encodings never taken
  always_comb begin
    case (issue.ctrl.funct3)
      3'b000:  cond = issue.rs1_val == issue.rs2_val;
      3'b001:  cond = issue.rs1_val != issue.rs2_val;
      3'b100:  cond = $signed(issue.rs1_val) < $signed(issue.rs2_val);
      3'b101:  cond = $signed(issue.rs1_val) >= $signed(issue.rs2_val);
      3'b110:  cond = issue.rs1_val < issue.rs2_val;
      3'b111:  cond = issue.rs1_val >= issue.rs2_val;
      default: cond = 1'b0;
    endcase
  end

  always_comb begin
    result.pc    = issue.pc;
    result.rd    = issue.rd;
    result.wb_en = issue.ctrl.wb_en;
    // Zero when nothing is written, keeps the stream deterministic
    if (!issue.ctrl.wb_en) begin
      result.wb_data = '0;
    end else if (issue.ctrl.wb_link) begin
      result.wb_data = pc_plus4;
    end else begin
      result.wb_data = alu_out;
    end
    // Jumps always count as taken
    result.taken = (issue.ctrl.is_branch && cond) || issue.ctrl.is_jal || issue.ctrl.is_jalr;
    if (issue.ctrl.is_jalr) begin
      result.next_pc = {alu_out[`RV_XLEN-1:1], 1'b0};
    end else if (issue.ctrl.is_jal || (issue.ctrl.is_branch && cond)) begin
      result.next_pc = pc_plus_imm;
    end else begin
      result.next_pc = pc_plus4;
    end
    result.is_mem   = issue.ctrl.is_mem;
    // rs1+imm from the adder
    result.mem_addr = issue.ctrl.is_mem ? alu_out : '0;
  end

endmodule

// ==== hw/register_file.sv ====
/*
 * Integer register file
 * Two combinational read ports, one synchronous write port, x0 fixed at zero
 */

`timescale 1ns/100ps

`include "rv_defs.svh"

module register_file (
  input  logic                 clock,
  input  logic                 rst,
  input  logic [`RV_REG_W-1:0] rs1,
  input  logic [`RV_REG_W-1:0] rs2,
  output logic [`RV_XLEN-1:0]  rs1_val,
  output logic [`RV_XLEN-1:0]  rs2_val,
  input  logic                 we,
  input  logic [`RV_REG_W-1:0] wa,
  input  logic [`RV_XLEN-1:0]  wd
);

  logic [`RV_XLEN-1:0] regs [`RV_NREGS];

  // Architectural state is defined after reset
  always_ff @(posedge clock) begin
    if (rst) begin
      for (int i = 0; i < `RV_NREGS; i++) begin
        regs[i] <= '0;
      end
    end else if (we && (wa != '0)) begin
      regs[wa] <= wd;
    end
  end

  // x0 never written, still masked here on read
  assign rs1_val = (rs1 == '0) ? '0 : regs[rs1];
  assign rs2_val = (rs2 == '0) ? '0 : regs[rs2];

endmodule

// ==== hw/instruction_decoder.sv ====
/*
 * Instruction decoder
 * Register indices and control flags for the kept RV32I classes
 */

`timescale 1ns/100ps

`include "rv_defs.svh"

module instruction_decoder import rv_pkg::*; (
  input  logic [`RV_ILEN-1:0]  inst,
  output logic [`RV_REG_W-1:0] rs1,
  output logic [`RV_REG_W-1:0] rs2,
  output logic [`RV_REG_W-1:0] rd,
  output ctrl_t                ctrl
);

  logic [6:0] opcode;
  logic [2:0] funct3;
  // funct7 bit 30 picks SUB and SRA
  logic       alt;

  assign opcode = inst[6:0];
  assign funct3 = inst[14:12];
  assign alt    = inst[30];

  // Shared funct3 map of OP and OP_IMM
  // allow_sub is low for OP_IMM, there is no SUBI
  function automatic alu_op_t arith_op(logic [2:0] f3, logic f7_alt, logic allow_sub);
    alu_op_t op;
    case (f3)
      3'b000:  op = (allow_sub && f7_alt) ? ALU_SUB : ALU_ADD;
      3'b001:  op = ALU_SLL;
      3'b010:  op = ALU_SLT;
      3'b011:  op = ALU_SLTU;
      3'b100:  op = ALU_XOR;
      3'b101:  op = f7_alt ? ALU_SRA : ALU_SRL;
      3'b110:  op = ALU_OR;
      default: op = ALU_AND;
    endcase
    return op;
  endfunction

  always_comb begin
    // Defaults describe a no-writeback passthrough
    ctrl        = '0;
    ctrl.alu_op = ALU_ADD;
    ctrl.funct3 = funct3;
    rs1         = inst[19:15];
    rs2         = inst[24:20];
    rd          = inst[11:7];
    case (opcode_t'(opcode))
      OPCODE_OP: begin
        ctrl.alu_op = arith_op(funct3, alt, 1'b1);
        ctrl.wb_en  = 1'b1;
      end
      OPCODE_OP_IMM: begin
        ctrl.alu_op    = arith_op(funct3, alt, 1'b0);
        ctrl.src_b_imm = 1'b1;
        ctrl.wb_en     = 1'b1;
      end
      // rs1 forced to x0 so operand A reads zero
      OPCODE_LUI: begin
        rs1            = '0;
        ctrl.src_b_imm = 1'b1;
        ctrl.wb_en     = 1'b1;
      end
      OPCODE_AUIPC: begin
        rs1            = '0;
        ctrl.src_a_pc  = 1'b1;
        ctrl.src_b_imm = 1'b1;
        ctrl.wb_en     = 1'b1;
      end
      OPCODE_JAL: begin
        rs1          = '0;
        ctrl.wb_en   = 1'b1;
        ctrl.wb_link = 1'b1;
        ctrl.is_jal  = 1'b1;
      end
      // Target is rs1+imm through the ALU adder
      OPCODE_JALR: begin
        ctrl.src_b_imm = 1'b1;
        ctrl.wb_en     = 1'b1;
        ctrl.wb_link   = 1'b1;
        ctrl.is_jalr   = 1'b1;
      end
      OPCODE_BRANCH: begin
        ctrl.is_branch = 1'b1;
      end
      // Effective address only, no memory behind it
      OPCODE_LOAD, OPCODE_STORE: begin
        ctrl.src_b_imm = 1'b1;
        ctrl.is_mem    = 1'b1;
      end
      default: begin
        ctrl.alu_op = ALU_ADD;
      end
    endcase
  end

endmodule

// ==== hw/immediate_generator.sv ====
/*
 * Immediate generator
 * Picks the I, S, B, U or J immediate from the opcode, sign extended
 */

`timescale 1ns/100ps

`include "rv_defs.svh"

module immediate_generator import rv_pkg::*; (
  input  logic                clock,
  input  logic [`RV_ILEN-1:0] inst,
  output logic [`RV_XLEN-1:0] immediate
);

  // Purely combinational, clock is only part of the port list

  always_comb begin
    case (opcode_t'(inst[6:0]))
      // I format, loads, register-immediate ops and jalr
      OPCODE_LOAD, OPCODE_LOAD_FP, OPCODE_OP_IMM, OPCODE_JALR: begin
        immediate = {{21{inst[31]}}, inst[30:25], inst[24:20]};
      end
      // S format splits the offset around rd
      OPCODE_STORE, OPCODE_STORE_FP: begin
        immediate = {{21{inst[31]}}, inst[30:25], inst[11:7]};
      end
      // B format, offset in halfwords
      OPCODE_BRANCH: begin
        immediate = {{20{inst[31]}}, inst[7], inst[30:25], inst[11:8], 1'b0};
      end
      // U format, upper 20 bits
      OPCODE_LUI, OPCODE_AUIPC: begin
        immediate = {inst[31:12], 12'b0};
      end
      // J format, scrambled 20 bit offset
      OPCODE_JAL: begin
        immediate = {{12{inst[31]}}, inst[19:12], inst[20], inst[30:25], inst[24:21], 1'b0};
      end
      // Unsupported opcodes carry no immediate
      default: begin
        immediate = '0;
      end
    endcase
  end

endmodule

// ==== hw/rv_pkg.sv ====
/*
 * RV32I integer slice types
 * Opcodes, ALU operations and the records passed down the pipeline
 */

`include "rv_defs.svh"

package rv_pkg;

  // Major opcodes, bits [6:0] of the instruction
  typedef enum logic [6:0] {
    OPCODE_LOAD     = 7'b0000011,
    OPCODE_LOAD_FP  = 7'b0000111,
    OPCODE_OP_IMM   = 7'b0010011,
    OPCODE_AUIPC    = 7'b0010111,
    OPCODE_STORE    = 7'b0100011,
    OPCODE_STORE_FP = 7'b0100111,
    OPCODE_OP       = 7'b0110011,
    OPCODE_LUI      = 7'b0110111,
    OPCODE_BRANCH   = 7'b1100011,
    OPCODE_JALR     = 7'b1100111,
    OPCODE_JAL      = 7'b1101111
  } opcode_t;

  // ALU function select
  typedef enum logic [3:0] {
    ALU_ADD,
    ALU_SUB,
    ALU_SLL,
    ALU_SLT,
    ALU_SLTU,
    ALU_XOR,
    ALU_SRL,
    ALU_SRA,
    ALU_OR,
    ALU_AND
  } alu_op_t;

  // Decoded control, one per instruction
  typedef struct packed {
    alu_op_t    alu_op;
    logic       src_a_pc;
    logic       src_b_imm;
    logic       wb_en;
    // Write pc+4 instead of the ALU output
    logic       wb_link;
    logic       is_branch;
    logic       is_jal;
    logic       is_jalr;
    logic       is_mem;
    // Branch condition lives here
    logic [2:0] funct3;
  } ctrl_t;

  // Decode/read stage to execute
  typedef struct packed {
    logic [`RV_XLEN-1:0]  pc;
    logic [`RV_XLEN-1:0]  imm;
    logic [`RV_XLEN-1:0]  rs1_val;
    logic [`RV_XLEN-1:0]  rs2_val;
    logic [`RV_REG_W-1:0] rd;
    ctrl_t                ctrl;
  } issue_t;

  // Output stream record
  typedef struct packed {
    logic [`RV_XLEN-1:0]  pc;
    logic [`RV_REG_W-1:0] rd;
    logic                 wb_en;
    logic [`RV_XLEN-1:0]  wb_data;
    logic                 taken;
    logic [`RV_XLEN-1:0]  next_pc;
    logic                 is_mem;
    logic [`RV_XLEN-1:0]  mem_addr;
  } result_t;

endpackage

// ==== hw/rv_defs.svh ====
/*
 * RV32I integer slice sizing
 * Data width and register file geometry shared by package and RTL
 */

`ifndef RV_DEFS_SVH
`define RV_DEFS_SVH

// Data path width, RV32 only
`define RV_XLEN 32

// Architectural integer registers, x0 included
`define RV_NREGS 32

// Bits needed to address one register
`define RV_REG_W 5

// Raw instruction width, fixed by the base ISA
`define RV_ILEN 32

// Fixed pc step for sequential flow, no compressed instructions here
`define RV_PC_STEP 4

`endif
